// ==== int_wb.f ====
+incdir+include
design/int_wb_pkg.sv
design/int_pipe.sv
design/wb_queue.sv
design/wb_regfile.sv
design/int_wb_core.sv
tb/int_wb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module int_wb_tb -f int_wb.f -o int_wb_sim

./obj_dir/int_wb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation result: PASS"
    exit 0
else
    echo "Simulation result: FAIL"
    exit 1
fi

// ==== include/int_wb_ref.svh ====
`ifndef INT_WB_REF_SVH
`define INT_WB_REF_SVH

// Expected result of one issued operation
function automatic xlen_t alu_ref(input issue_op_t op);
    xlen_t       a;
    xlen_t       b;
    xlen_t       r;
    logic [31:0] w;
    int unsigned sh;
    a = op.operand1;
    b = op.operand2;
    sh = op.truncate ? b[4:0] : b[5:0];
    case (op.op)
        ALU_ADD:  r = op.option ? a - b : a + b;
        ALU_SLL:  r = a << sh;
        ALU_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        ALU_SLTU: r = (a < b) ? 64'd1 : 64'd0;
        ALU_XOR:  r = a ^ b;
        ALU_SRL: begin
            if (op.truncate) begin
                // Word shift works on the low half alone
                if (op.option) begin
                    w = $signed(a[31:0]) >>> sh;
                end else begin
                    w = a[31:0] >> sh;
                end
                r = {32'b0, w};
            end else if (op.option) begin
                r = $signed(a) >>> sh;
            end else begin
                r = a >> sh;
            end
        end
        ALU_OR:   r = a | b;
        ALU_AND:  r = a & b;
        default:  r = '0;
    endcase
    if (op.truncate) begin
        r = {{32{r[31]}}, r[31:0]};
    end
    return r;
endfunction

// Galois LFSR stepped once per random bit
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return (state >> 1) ^ (state[0] ? 32'hA300_0000 : 32'h0);
endfunction

task automatic check_entry(input string name, input wb_entry_t got, input wb_entry_t exp,
                           inout int checks, inout int errors);
    checks++;
    if (got !== exp) begin
        errors++;
        $write("FAIL %s: got pc=%h dst=%h wb_en=%h result=%h",
               name, got.pc, got.dst, got.wb_en, got.result);
        $display(", expected pc=%h dst=%h wb_en=%h result=%h",
                 exp.pc, exp.dst, exp.wb_en, exp.result);
    end
endtask

task automatic check_reg(input string name, input xlen_t got, input xlen_t exp,
                         inout int checks, inout int errors);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
endtask

`endif

// ==== tb/int_wb_tb.sv ====
`default_nettype none

module int_wb_tb import int_wb_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int QUEUE_DEPTH = 4;
    localparam int WAIT_LIMIT = 2000;

    logic      clk;
    logic      rst_n;
    logic      issue_valid;
    logic      issue_ready;
    logic      wb_grant;
    logic      wb_valid;
    logic      grant_random;
    issue_op_t issue_op;
    wb_entry_t wb_entry;
    reg_idx_t  rf_rsrc;
    xlen_t     rf_rdata;

    logic [31:0] lfsr;
    wb_entry_t   exp_q [$];
    logic        trunc_q [$];
    xlen_t       model_regs [REG_COUNT];
    int          checks;
    int          errors;
    int          accepted;
    int          pulses;

    int_wb_core #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (.*);

    `include "int_wb_ref.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic issue_op_t make_op();
        issue_op_t op;
        op.pc = take_bits(32) << 2;
        op.dst = reg_idx_t'(take_bits(5));
        // Mostly writing ops, a few with wb_en clear
        op.wb_en = (take_bits(3) != 0);
        op.op = alu_op_e'(4'(take_bits(3)));
        op.option = (take_bits(1) != 0);
        op.truncate = (take_bits(2) == 0);
        op.operand1 = take_bits(64);
        op.operand2 = take_bits(64);
        return op;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (grant_random) begin
            wb_grant = (take_bits(1) != 0);
        end
    endtask

    task automatic abort_run(input string what);
        errors++;
        $display("Timeout: %s", what);
        $display("Checks failed");
        $finish;
    endtask

    // Expected entry and model register update for an accepted op
    task automatic record(input issue_op_t op);
        wb_entry_t e;
        e = '{op.pc, op.dst, op.wb_en, alu_ref(op)};
        exp_q.push_back(e);
        trunc_q.push_back(op.truncate);
        if (op.wb_en && op.dst != '0) begin
            model_regs[op.dst] = e.result;
        end
        accepted++;
    endtask

    // Leaves issue_valid high for the caller to drop or reuse
    task automatic issue_one(input issue_op_t op);
        int   waited;
        logic took;
        waited = 0;
        took = 1'b0;
        issue_valid = 1'b1;
        issue_op = op;
        while (!took) begin
            @(negedge clk);
            took = issue_ready;
            next_cycle();
            waited++;
            if (!took && waited > WAIT_LIMIT) begin
                abort_run("issue_ready stayed low");
            end
        end
        record(op);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("outstanding operations never committed");
            end
        end
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < REG_COUNT; i++) begin
            rf_rsrc = reg_idx_t'(i);
            @(negedge clk);
            check_reg($sformatf("rf_rdata x%0d", i), rf_rdata, model_regs[i], checks, errors);
            next_cycle();
        end
    endtask

    // Commit reports are compared in issue order
    initial begin : compare
        wb_entry_t exp_e;
        logic      trunc;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && wb_valid === 1'b1) begin
                pulses++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("wb_valid pulse with no operation outstanding");
                end else begin
                    exp_e = exp_q.pop_front();
                    trunc = trunc_q.pop_front();
                    check_entry("wb_entry", wb_entry, exp_e, checks, errors);
                    if (trunc) begin
                        check_reg("wb_entry.result[63:31]",
                                  xlen_t'(wb_entry.result[63:31]),
                                  xlen_t'({33{exp_e.result[31]}}),
                                  checks, errors);
                    end
                end
            end
        end
    end

    initial begin : main
        int        err0;
        issue_op_t op;
        rst_n = 1'b0;
        issue_valid = 1'b0;
        issue_op = '0;
        wb_grant = 1'b0;
        rf_rsrc = '0;
        grant_random = 1'b0;
        lfsr = 32'h7f0e;
        checks = 0;
        errors = 0;
        accepted = 0;
        pulses = 0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        err0 = errors;
        @(negedge clk);
        check_reg("issue_ready", xlen_t'(issue_ready), 64'd1, checks, errors);
        check_reg("wb_valid", xlen_t'(wb_valid), 64'd0, checks, errors);
        next_cycle();
        check_all_regs();
        $display("Test 1 reset state: %0d errors", errors - err0);

        // Every opcode with option clear and set
        err0 = errors;
        wb_grant = 1'b1;
        for (int i = 0; i < 200; i++) begin
            op = make_op();
            op.op = alu_op_e'(4'(i % 8));
            op.option = i[3];
            issue_one(op);
        end
        issue_valid = 1'b0;
        wait_drain();
        $display("Test 2 random ops in order: %0d errors", errors - err0);

        err0 = errors;
        for (int i = 0; i < 40; i++) begin
            op = make_op();
            op.truncate = 1'b1;
            issue_one(op);
        end
        issue_valid = 1'b0;
        wait_drain();
        $display("Test 3 word ops: %0d errors", errors - err0);

        // Queue plus pipe register hold QUEUE_DEPTH+1 ops
        err0 = errors;
        wb_grant = 1'b0;
        for (int i = 0; i < QUEUE_DEPTH + 1; i++) begin
            issue_one(make_op());
        end
        issue_op = make_op();
        repeat (8) begin
            @(negedge clk);
            check_reg("issue_ready", xlen_t'(issue_ready), 64'd0, checks, errors);
            next_cycle();
        end
        issue_valid = 1'b0;
        wb_grant = 1'b1;
        wait_drain();
        $display("Test 4 back-pressure: %0d errors", errors - err0);

        err0 = errors;
        op = make_op();
        op.dst = '0;
        op.wb_en = 1'b1;
        issue_one(op);
        op = make_op();
        op.dst = 5'd7;
        op.wb_en = 1'b0;
        issue_one(op);
        issue_valid = 1'b0;
        wait_drain();
        check_all_regs();
        $display("Test 5 register contents: %0d errors", errors - err0);

        err0 = errors;
        grant_random = 1'b1;
        for (int i = 0; i < 150; i++) begin
            issue_one(make_op());
        end
        issue_valid = 1'b0;
        wait_drain();
        grant_random = 1'b0;
        wb_grant = 1'b1;
        check_reg("wb_valid pulses", xlen_t'(pulses), xlen_t'(accepted), checks, errors);
        $display("Test 6 random grant: %0d errors", errors - err0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/int_wb_core.sv ====
`default_nettype none

module int_wb_core import int_wb_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    // Issue side
    input  logic      issue_valid,
    input  issue_op_t issue_op,
    output logic      issue_ready,
    // Write port arbiter
    input  logic      wb_grant,
    // Commit report and read port
    output logic      wb_valid,
    output wb_entry_t wb_entry,
    input  reg_idx_t  rf_rsrc,
    output xlen_t     rf_rdata
);

    logic      exec_valid;
    wb_entry_t exec_entry;
    logic      exec_ready;
    logic      commit_valid;
    wb_entry_t commit_entry;
    logic      commit_ready;

    int_pipe pipe0 (
        .clk(clk),
        .rst_n(rst_n),
        .issue_valid(issue_valid),
        .issue_op(issue_op),
        .issue_ready(issue_ready),
        .exec_valid(exec_valid),
        .exec_entry(exec_entry),
        .exec_ready(exec_ready)
    );

    wb_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue0 (
        .clk(clk),
        .rst_n(rst_n),
        .exec_valid(exec_valid),
        .exec_entry(exec_entry),
        .exec_ready(exec_ready),
        .commit_valid(commit_valid),
        .commit_entry(commit_entry),
        .commit_ready(commit_ready)
    );

    wb_regfile regfile0 (
        .clk(clk),
        .rst_n(rst_n),
        .commit_valid(commit_valid),
        .commit_entry(commit_entry),
        .commit_ready(commit_ready),
        .wb_grant(wb_grant),
        .wb_valid(wb_valid),
        .wb_entry(wb_entry),
        .rf_rsrc(rf_rsrc),
        .rf_rdata(rf_rdata)
    );

endmodule

`default_nettype wire

// ==== design/wb_regfile.sv ====
`default_nettype none

module wb_regfile import int_wb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      commit_valid,
    input  wb_entry_t commit_entry,
    output logic      commit_ready,
    input  logic      wb_grant,
    output logic      wb_valid,
    output wb_entry_t wb_entry,
    input  reg_idx_t  rf_rsrc,
    output xlen_t     rf_rdata
);

    // x0 has no storage
    xlen_t regs [1:REG_COUNT-1];
    logic  commit;

    // Write port belongs to the arbiter
    assign commit_ready = wb_grant;
    assign commit = commit_valid && wb_grant;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (commit && commit_entry.wb_en && commit_entry.dst != '0) begin
            regs[commit_entry.dst] <= commit_entry.result;
        end
    end

    always_comb begin
        if (rf_rsrc == '0) begin
            rf_rdata = '0;
        end else begin
            rf_rdata = regs[rf_rsrc];
        end
    end

    // Every commit is reported, wb_en clear or not
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= commit;
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            wb_entry <= commit_entry;
        end
    end

endmodule

`default_nettype wire

// ==== design/wb_queue.sv ====
`default_nettype none

module wb_queue import int_wb_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      exec_valid,
    input  wb_entry_t exec_entry,
    output logic      exec_ready,
    output logic      commit_valid,
    output wb_entry_t commit_entry,
    input  logic      commit_ready
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    wb_entry_t        entries [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == CNT_W'(QUEUE_DEPTH));
    assign commit_valid = (count != '0);
    assign commit_entry = entries[rd_ptr];

    // A pop frees the slot the push needs
    assign exec_ready = !full || commit_ready;

    assign push = exec_valid && exec_ready;
    assign pop = commit_valid && commit_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= exec_entry;
        end
    end

endmodule

`default_nettype wire

// ==== design/int_pipe.sv ====
`default_nettype none

module int_pipe import int_wb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  issue_op_t issue_op,
    output logic      issue_ready,
    output logic      exec_valid,
    output wb_entry_t exec_entry,
    input  logic      exec_ready
);

    xlen_t      op1;
    xlen_t      op2;
    logic [5:0] shamt;
    xlen_t      sr_src;
    xlen_t      sra_res;
    xlen_t      alu_res;
    xlen_t      result;

    assign op1 = issue_op.operand1;
    assign op2 = issue_op.operand2;

    // Word ops shift by at most 31
    assign shamt = issue_op.truncate ? {1'b0, op2[4:0]} : op2[5:0];

    // Word right shifts only see the low word of operand1
    always_comb begin
        if (!issue_op.truncate) begin
            sr_src = op1;
        end else if (issue_op.option) begin
            sr_src = {{32{op1[31]}}, op1[31:0]};
        end else begin
            sr_src = {32'b0, op1[31:0]};
        end
    end

    assign sra_res = $signed(sr_src) >>> shamt;

    always_comb begin
        case (issue_op.op)
            ALU_ADD:  alu_res = issue_op.option ? op1 - op2 : op1 + op2;
            ALU_SLL:  alu_res = op1 << shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op1 < op2};
            ALU_XOR:  alu_res = op1 ^ op2;
            ALU_SRL:  alu_res = issue_op.option ? sra_res : sr_src >> shamt;
            ALU_OR:   alu_res = op1 | op2;
            ALU_AND:  alu_res = op1 & op2;
            default:  alu_res = '0;
        endcase
    end

    assign result = issue_op.truncate ? {{32{alu_res[31]}}, alu_res[31:0]} : alu_res;

    // Free slot, or the held result leaves this cycle
    assign issue_ready = !exec_valid || exec_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec_valid <= 1'b0;
        end else if (issue_ready) begin
            exec_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            exec_entry.pc     <= issue_op.pc;
            exec_entry.dst    <= issue_op.dst;
            exec_entry.wb_en  <= issue_op.wb_en;
            exec_entry.result <= result;
        end
    end

endmodule

`default_nettype wire

// ==== design/int_wb_pkg.sv ====
`default_nettype none

package int_wb_pkg;

    // Datapath width of the core
    parameter int XLEN = 64;

    // Architectural integer registers, x0 included
    parameter int REG_COUNT = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

    // Encodings follow the funct3 field of the integer ops
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SLL  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SRL  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_AND  = 4'd7
    } alu_op_e;

    // Operation as issued to the integer pipe
    typedef struct packed {
        xlen_t    pc;
        reg_idx_t dst;
        logic     wb_en;
        alu_op_e  op;
        // Turns add into sub and srl into sra
        logic     option;
        // Word form, result is sign-extended from bit 31
        logic     truncate;
        xlen_t    operand1;
        xlen_t    operand2;
    } issue_op_t;

    // Result on its way to the register file
    typedef struct packed {
        xlen_t    pc;
        reg_idx_t dst;
        logic     wb_en;
        xlen_t    result;
    } wb_entry_t;

endpackage

`default_nettype wire
